// ==== Makefile ====
TOOL   := verilator
FLAGS  := --binary --timing -Wno-fatal
TOP    := tb_exu
FLIST  := project.f
LOG    := sim.log

SRCS   := $(shell grep -v '^+' $(FLIST)) rtl/exu_config.svh
BIN    := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_ctrl.sv
rtl/exu_ialu.sv
rtl/exu_lsu.sv
rtl/exu_wb.sv
rtl/exu_top.sv
test/tb_models.sv
test/tb_exu.sv

// ==== rtl/exu_config.svh ====
/*
 * Execute stage configuration
 * Data and register widths, reset vector and trap vector
 */

`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// ----------------------------------------------------------
// Widths
// ----------------------------------------------------------
`define EXU_XLEN        32              // Data and address width
`define EXU_RF_AWIDTH   5               // Register file address width

// ----------------------------------------------------------
// Program counter vectors
// ----------------------------------------------------------
`define EXU_RST_VECTOR  32'h0000_0200   // PC after reset
`define EXU_TRAP_VECTOR 32'h0000_0100   // Target of every exception

`endif

// ==== rtl/exu_ctrl.sv ====
/*
 * Execute stage control
 * Command register, PC, readiness, exceptions and redirects
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  exu_pkg::exu_cmd_t           cmd,
    input  logic                        ialu_cmp,
    input  logic [`EXU_XLEN-1:0]        sum2_res,
    input  logic                        lsu_rdy,
    input  logic                        lsu_exc,
    input  exu_pkg::exc_code_e          lsu_exc_code,
    output logic                        cmd_ready,
    output logic                        q_valid,
    output exu_pkg::exu_cmd_t           q_cmd,
    output logic [`EXU_RF_AWIDTH-1:0]   rs1_addr,
    output logic [`EXU_RF_AWIDTH-1:0]   rs2_addr,
    output logic                        commit,
    output logic                        instret,
    output logic                        exc_req,
    output exu_pkg::trap_t              trap,
    output logic                        new_pc_req,
    output logic [`EXU_XLEN-1:0]        new_pc,
    output logic [`EXU_XLEN-1:0]        curr_pc
);
    import exu_pkg::*;

    logic                   run_en;
    logic                   lsu_req;
    logic                   exu_rdy;
    logic                   jb_taken;
    logic                   jb_misalign;
    logic                   exc_any;
    logic [`EXU_XLEN-1:0]   jb_target;

    // ----------------------------------------------------------
    // Command register
    // ----------------------------------------------------------
    assign lsu_req   = q_valid & (q_cmd.lsu_cmd != LSU_CMD_NONE) & ~q_cmd.exc_req;
    assign exu_rdy   = lsu_req ? (lsu_rdy | lsu_exc) : 1'b1;
    assign instret   = q_valid & exu_rdy;
    assign cmd_ready = run_en & (~q_valid | exu_rdy) & ~new_pc_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_en  <= 1'b0;
            q_valid <= 1'b0;
        end else begin
            run_en <= 1'b1;                     // First cycle out of reset
            if (cmd_ready) begin
                q_valid <= cmd_valid;
            end else if (instret) begin
                q_valid <= 1'b0;                // Redirect drops the slot
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_valid) begin
            q_cmd <= cmd;
        end
    end

    assign rs1_addr = q_cmd.rs1_addr;
    assign rs2_addr = q_cmd.rs2_addr;

    // ----------------------------------------------------------
    // Exceptions and redirect
    // ----------------------------------------------------------
    assign jb_taken    = q_cmd.jump_req | (q_cmd.branch_req & ialu_cmp);
    assign jb_target   = {sum2_res[`EXU_XLEN-1:1], 1'b0};
    assign jb_misalign = jb_taken & (jb_target[1:0] != 2'b00);
    assign exc_any     = q_cmd.exc_req | lsu_exc | jb_misalign;

    assign exc_req    = instret & exc_any;
    assign commit     = instret & ~exc_any;
    assign new_pc_req = instret & (exc_any | jb_taken);
    assign new_pc     = exc_any ? `EXU_TRAP_VECTOR : jb_target;

    // Decoder first, then LSU, then target
    always_comb begin
        if (q_cmd.exc_req) begin
            trap.exc_code = q_cmd.exc_code;
            trap.trap_val = curr_pc;
        end else if (lsu_exc) begin
            trap.exc_code = lsu_exc_code;
            trap.trap_val = sum2_res;           // Faulting address
        end else begin
            trap.exc_code = EXC_CODE_INSTR_MISALIGN;
            trap.trap_val = jb_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= `EXU_RST_VECTOR;
        end else if (instret) begin
            curr_pc <= new_pc_req ? new_pc : curr_pc + `EXU_XLEN'd4;
        end
    end

    a_one_flow: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid |-> $onehot0({q_cmd.jump_req, q_cmd.branch_req, q_cmd.lsu_cmd != LSU_CMD_NONE}))
        else $error("jump, branch and load/store set together");

    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && !instret |=> $stable(q_cmd))
        else $error("command register changed before retirement");

endmodule

// ==== rtl/exu_ialu.sv ====
/*
 * Integer ALU with separate sum2 adder
 * Sum2 gives jump targets and load/store addresses
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_ialu (
    input  exu_pkg::exu_cmd_t       q_cmd,
    input  logic [`EXU_XLEN-1:0]    rs1_data,
    input  logic [`EXU_XLEN-1:0]    rs2_data,
    input  logic [`EXU_XLEN-1:0]    curr_pc,
    output logic [`EXU_XLEN-1:0]    ialu_res,
    output logic                    ialu_cmp,
    output logic [`EXU_XLEN-1:0]    sum2_res
);
    import exu_pkg::*;

    localparam int XLEN = `EXU_XLEN;
    localparam int SHW  = $clog2(XLEN);

    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [XLEN:0]      sub_res;                // Extra bit holds the borrow
    logic [SHW-1:0]     shamt;
    logic               eq;
    logic               lt;
    logic               ltu;

    assign op1   = rs1_data;
    assign op2   = (q_cmd.ialu_op == IALU_OP_REG_REG) ? rs2_data : q_cmd.imm;
    assign shamt = op2[SHW-1:0];

    // ----------------------------------------------------------
    // Compare
    // ----------------------------------------------------------
    assign sub_res = {1'b0, op1} - {1'b0, op2};
    assign eq      = (op1 == op2);
    assign ltu     = sub_res[XLEN];
    assign lt      = (op1[XLEN-1] ^ op2[XLEN-1]) ? op1[XLEN-1] : sub_res[XLEN-1];

    always_comb begin
        case (q_cmd.ialu_cmd)
            IALU_CMD_EQ:                 ialu_cmp = eq;
            IALU_CMD_NE:                 ialu_cmp = ~eq;
            IALU_CMD_LT, IALU_CMD_SLT:   ialu_cmp = lt;
            IALU_CMD_GE:                 ialu_cmp = ~lt;
            IALU_CMD_LTU, IALU_CMD_SLTU: ialu_cmp = ltu;
            IALU_CMD_GEU:                ialu_cmp = ~ltu;
            default:                     ialu_cmp = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // Result
    // ----------------------------------------------------------
    always_comb begin
        case (q_cmd.ialu_cmd)
            IALU_CMD_ADD:  ialu_res = op1 + op2;
            IALU_CMD_SUB:  ialu_res = sub_res[XLEN-1:0];
            IALU_CMD_AND:  ialu_res = op1 & op2;
            IALU_CMD_OR:   ialu_res = op1 | op2;
            IALU_CMD_XOR:  ialu_res = op1 ^ op2;
            IALU_CMD_SLL:  ialu_res = op1 << shamt;
            IALU_CMD_SRL:  ialu_res = op1 >> shamt;
            IALU_CMD_SRA:  ialu_res = $signed(op1) >>> shamt;
            default:       ialu_res = XLEN'(ialu_cmp);     // Set-less-than and compares
        endcase
    end

    assign sum2_res = ((q_cmd.sum2_op == SUM2_OP_REG_IMM) ? rs1_data : curr_pc) + q_cmd.imm;

endmodule

// ==== rtl/exu_lsu.sv ====
/*
 * Load/store unit
 * Data memory handshake, misalignment check, load extension
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_lsu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    q_valid,
    input  exu_pkg::exu_cmd_t       q_cmd,
    input  logic [`EXU_XLEN-1:0]    addr,
    input  logic [`EXU_XLEN-1:0]    rs2_data,
    input  logic                    dmem_ack,
    input  logic [`EXU_XLEN-1:0]    dmem_rdata,
    input  exu_pkg::mem_resp_e      dmem_resp,
    output logic                    dmem_req,
    output exu_pkg::dmem_req_t      dmem_cmd,
    output logic                    lsu_rdy,
    output logic                    lsu_exc,
    output exu_pkg::exc_code_e      lsu_exc_code,
    output logic [`EXU_XLEN-1:0]    l_data
);
    import exu_pkg::*;

    typedef enum logic [1:0] {LSU_IDLE, LSU_WAIT_ACK, LSU_WAIT_RESP} lsu_state_e;

    lsu_state_e             state;
    logic                   go;
    logic                   store;
    logic                   misalign;
    logic [`EXU_XLEN-1:0]   rd_shift;

    assign go    = q_valid & (q_cmd.lsu_cmd != LSU_CMD_NONE) & ~q_cmd.exc_req;
    assign store = (q_cmd.lsu_cmd inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW});

    always_comb begin
        case (q_cmd.lsu_cmd)
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: dmem_cmd.width = MEM_WIDTH_HWORD;
            LSU_CMD_LW, LSU_CMD_SW:              dmem_cmd.width = MEM_WIDTH_WORD;
            default:                             dmem_cmd.width = MEM_WIDTH_BYTE;
        endcase
    end

    assign misalign = ((dmem_cmd.width == MEM_WIDTH_HWORD) & addr[0])
                    | ((dmem_cmd.width == MEM_WIDTH_WORD) & (addr[1:0] != 2'b00));

    assign dmem_cmd.wr    = store;
    assign dmem_cmd.addr  = addr;
    assign dmem_cmd.wdata = rs2_data << {addr[1:0], 3'b000};   // Lane aligned

    // ----------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
        end else begin
            case (state)
                LSU_IDLE:      if (go && !misalign) state <= dmem_ack ? LSU_WAIT_RESP : LSU_WAIT_ACK;
                LSU_WAIT_ACK:  if (dmem_ack) state <= LSU_WAIT_RESP;
                default:       state <= LSU_IDLE;
            endcase
        end
    end

    assign dmem_req = ((state == LSU_IDLE) & go & ~misalign) | (state == LSU_WAIT_ACK);
    assign lsu_rdy  = (state == LSU_WAIT_RESP);
    assign lsu_exc  = ((state == LSU_IDLE) & go & misalign)
                    | (lsu_rdy & (dmem_resp == MEM_RESP_ERR));

    always_comb begin
        if (misalign) begin
            lsu_exc_code = store ? EXC_CODE_ST_ADDR_MISALIGN : EXC_CODE_LD_ADDR_MISALIGN;
        end else begin
            lsu_exc_code = store ? EXC_CODE_ST_ACCESS_FAULT : EXC_CODE_LD_ACCESS_FAULT;
        end
    end

    // Load extension
    assign rd_shift = dmem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (q_cmd.lsu_cmd)
            LSU_CMD_LB:  l_data = {{(`EXU_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            LSU_CMD_LH:  l_data = {{(`EXU_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            LSU_CMD_LBU: l_data = {{(`EXU_XLEN-8){1'b0}}, rd_shift[7:0]};
            LSU_CMD_LHU: l_data = {{(`EXU_XLEN-16){1'b0}}, rd_shift[15:0]};
            default:     l_data = rd_shift;
        endcase
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req && $stable(dmem_cmd))
        else $error("data memory request dropped or changed before acknowledge");

endmodule

// ==== rtl/exu_pkg.sv ====
/*
 * Execute stage types
 * Command, memory, write-back and trap encodings
 */

`include "exu_config.svh"

package exu_pkg;

    typedef enum logic {IALU_OP_REG_REG, IALU_OP_REG_IMM} ialu_op_e;
    typedef enum logic {SUM2_OP_REG_IMM, SUM2_OP_PC_IMM} sum2_op_e;

    typedef enum logic [4:0] {
        IALU_CMD_NONE, IALU_CMD_ADD, IALU_CMD_SUB, IALU_CMD_AND, IALU_CMD_OR,
        IALU_CMD_XOR, IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA, IALU_CMD_SLT,
        IALU_CMD_SLTU, IALU_CMD_EQ, IALU_CMD_NE, IALU_CMD_LT, IALU_CMD_GE,
        IALU_CMD_LTU, IALU_CMD_GEU
    } ialu_cmd_e;

    typedef enum logic [3:0] {
        LSU_CMD_NONE, LSU_CMD_LB, LSU_CMD_LH, LSU_CMD_LW, LSU_CMD_LBU,
        LSU_CMD_LHU, LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW
    } lsu_cmd_e;

    typedef enum logic [2:0] {
        RD_WB_NONE, RD_WB_IALU, RD_WB_SUM2, RD_WB_IMM, RD_WB_INC_PC, RD_WB_LSU
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        EXC_CODE_INSTR_MISALIGN   = 4'd0,
        EXC_CODE_ILLEGAL_INSTR    = 4'd2,
        EXC_CODE_LD_ADDR_MISALIGN = 4'd4,
        EXC_CODE_LD_ACCESS_FAULT  = 4'd5,
        EXC_CODE_ST_ADDR_MISALIGN = 4'd6,
        EXC_CODE_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

    typedef enum logic [1:0] {MEM_WIDTH_BYTE, MEM_WIDTH_HWORD, MEM_WIDTH_WORD} mem_width_e;
    typedef enum logic {MEM_RESP_OK, MEM_RESP_ERR} mem_resp_e;

    // Decoded command as issued by the decoder
    typedef struct packed {
        ialu_op_e                   ialu_op;
        ialu_cmd_e                  ialu_cmd;
        sum2_op_e                   sum2_op;
        lsu_cmd_e                   lsu_cmd;
        rd_wb_sel_e                 rd_wb_sel;
        logic                       jump_req;
        logic                       branch_req;
        logic                       exc_req;        // Decoder flagged exception
        exc_code_e                  exc_code;
        logic [`EXU_RF_AWIDTH-1:0]  rs1_addr;
        logic [`EXU_RF_AWIDTH-1:0]  rs2_addr;
        logic [`EXU_RF_AWIDTH-1:0]  rd_addr;
        logic [`EXU_XLEN-1:0]       imm;
    } exu_cmd_t;

    typedef struct packed {
        logic                       wr;             // Store when set
        mem_width_e                 width;
        logic [`EXU_XLEN-1:0]       addr;
        logic [`EXU_XLEN-1:0]       wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                       en;
        logic [`EXU_RF_AWIDTH-1:0]  addr;
        logic [`EXU_XLEN-1:0]       data;
    } rf_wr_t;

    typedef struct packed {
        exc_code_e                  exc_code;
        logic [`EXU_XLEN-1:0]       trap_val;
    } trap_t;

endpackage

// ==== rtl/exu_top.sv ====
/*
 * Execute stage top level
 * Control beside ALU, load/store and write-back datapaths
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  exu_pkg::exu_cmd_t           cmd,
    output logic [`EXU_RF_AWIDTH-1:0]   rs1_addr,
    output logic [`EXU_RF_AWIDTH-1:0]   rs2_addr,
    input  logic [`EXU_XLEN-1:0]        rs1_data,
    input  logic [`EXU_XLEN-1:0]        rs2_data,
    output exu_pkg::rf_wr_t             rf_wr,
    output logic                        dmem_req,
    input  logic                        dmem_ack,
    output exu_pkg::dmem_req_t          dmem_cmd,
    input  logic [`EXU_XLEN-1:0]        dmem_rdata,
    input  exu_pkg::mem_resp_e          dmem_resp,
    output logic                        instret,
    output logic                        exc_req,
    output exu_pkg::trap_t              trap,
    output logic                        new_pc_req,
    output logic [`EXU_XLEN-1:0]        new_pc,
    output logic [`EXU_XLEN-1:0]        curr_pc
);
    import exu_pkg::*;

    logic                   q_valid;
    exu_cmd_t               q_cmd;
    logic                   commit;
    logic [`EXU_XLEN-1:0]   ialu_res;
    logic                   ialu_cmp;
    logic [`EXU_XLEN-1:0]   sum2_res;
    logic                   lsu_rdy;
    logic                   lsu_exc;
    exc_code_e              lsu_exc_code;
    logic [`EXU_XLEN-1:0]   l_data;

    exu_ctrl u_ctrl (
        .clk, .rst_n, .cmd_valid, .cmd, .ialu_cmp, .sum2_res,
        .lsu_rdy, .lsu_exc, .lsu_exc_code, .cmd_ready, .q_valid, .q_cmd,
        .rs1_addr, .rs2_addr, .commit, .instret, .exc_req, .trap,
        .new_pc_req, .new_pc, .curr_pc
    );

    exu_ialu u_ialu (
        .q_cmd, .rs1_data, .rs2_data, .curr_pc, .ialu_res, .ialu_cmp, .sum2_res
    );

    exu_lsu u_lsu (
        .clk, .rst_n, .q_valid, .q_cmd,
        .addr       (sum2_res),         // Sum2 gives the address
        .rs2_data, .dmem_ack, .dmem_rdata, .dmem_resp,
        .dmem_req, .dmem_cmd, .lsu_rdy, .lsu_exc, .lsu_exc_code, .l_data
    );

    exu_wb u_wb (
        .q_cmd, .commit, .ialu_res, .sum2_res, .l_data, .curr_pc, .rf_wr
    );

endmodule

// ==== rtl/exu_wb.sv ====
/*
 * Register file write-back
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_wb (
    input  exu_pkg::exu_cmd_t       q_cmd,
    input  logic                    commit,
    input  logic [`EXU_XLEN-1:0]    ialu_res,
    input  logic [`EXU_XLEN-1:0]    sum2_res,
    input  logic [`EXU_XLEN-1:0]    l_data,
    input  logic [`EXU_XLEN-1:0]    curr_pc,
    output exu_pkg::rf_wr_t         rf_wr
);
    import exu_pkg::*;

    // No write to x0
    assign rf_wr.en   = commit & (q_cmd.rd_wb_sel != RD_WB_NONE) & (q_cmd.rd_addr != '0);
    assign rf_wr.addr = q_cmd.rd_addr;

    always_comb begin
        case (q_cmd.rd_wb_sel)
            RD_WB_SUM2:   rf_wr.data = sum2_res;
            RD_WB_IMM:    rf_wr.data = q_cmd.imm;
            RD_WB_INC_PC: rf_wr.data = curr_pc + `EXU_XLEN'd4;     // Link address
            RD_WB_LSU:    rf_wr.data = l_data;
            default:      rf_wr.data = ialu_res;
        endcase
    end

endmodule

// ==== test/exu_stim.txt ====
// test  rs1_val  rs2_val  op(ialu_op,cmd,sum2_op,lsu,wb,jump,branch,exc,code)  rs1_rs2_rd  imm
// kind(0 wb, 1 redirect, 2 exception, 3 none)  exp1(data/new_pc/code)  exp2(trap_val)
01 00000005 00000007 0010010000 010203 00000000 0 0000000c 0
02 00000003 00000005 0020010000 010203 00000000 0 fffffffe 0
03 80000010 00000000 1080010000 010003 00000004 0 f8000001 0
04 00000001 ffffffff 00a0010000 010204 00000000 0 00000001 0
05 000000ff 00000000 1050010000 010000 0000000f 3 00000000 0
06 00000000 00000000 0001041000 000001 00000040 1 00000254 0
07 00000301 00000000 0000041000 050001 00000010 1 00000310 0
08 00000009 00000009 00b1000100 010200 00000020 1 00000330 0
09 00000005 fffffffe 00d1000100 010200 00000020 3 00000000 0
0a 00000010 a1b2c3d4 0000800000 010200 00000004 3 00000000 0
0b 00000010 00000000 0000150000 010003 00000005 0 ffffffc3 0
0c 00000010 00000000 0000550000 010003 00000006 0 0000a1b2 0
0d 00000010 0000005a 0000600000 010200 00000007 3 00000000 0
0e 00000010 00000000 0000350000 010006 00000004 0 5ab2c3d4 0
0f 00000010 00000000 0000250000 010003 00000005 2 00000004 00000015
10 000003f0 00000000 0000800000 010200 00000010 2 00000007 00000400
11 00000000 00000000 0000000012 000000 00000000 2 00000002 00000100
12 00000000 00000000 0001001000 000000 00000006 2 00000000 00000106
13 00000010 00000000 0000800000 010200 00000002 2 00000006 00000012

// ==== test/tb_exu.sv ====
/*
 * Execute stage testbench
 * Runs commands from the stim file, then a back-to-back issue check
 */

`timescale 1ns/1ps
`include "exu_config.svh"

module tb_exu;
    import exu_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int NCOL      = 9;                       // Words per stim line

    logic           clk = 1'b0;
    logic           rst_n = 1'b0;
    logic           cmd_valid = 1'b0;
    exu_cmd_t       cmd = '0;
    logic           cmd_ready;
    logic [4:0]     rs1_addr;
    logic [4:0]     rs2_addr;
    logic [31:0]    rs1_data;
    logic [31:0]    rs2_data;
    rf_wr_t         rf_wr;
    logic           dmem_req;
    logic           dmem_ack;
    dmem_req_t      dmem_cmd;
    logic [31:0]    dmem_rdata;
    mem_resp_e      dmem_resp;
    logic           instret;
    logic           exc_req;
    trap_t          trap;
    logic           new_pc_req;
    logic [31:0]    new_pc;
    logic [31:0]    curr_pc;

    logic [63:0]    stim [0:MAX_TESTS*NCOL-1];
    logic [31:0]    exp_pc;
    int             n_tests = 0;
    int             n_pass = 0;
    int             n_fail = 0;
    int             errors = 0;
    int             cycle_cnt = 0;
    int             cycle_limit = 100000;

    exu_top dut0 (.*);
    rf_model rf0 (.clk, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .rf_wr);
    dmem_model mem0 (.clk, .rst_n, .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata, .dmem_resp);

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task check_val(input string what, input logic [31:0] got, input logic [31:0] exp,
                   input int tn);
        assert (got === exp) else begin
            $display("FAIL %0t test %0d: %s is %h, expected %h", $time, tn, what, got, exp);
            errors++;
        end
    endtask

    // Op word holds one field per hex digit, cmd takes two
    function automatic exu_cmd_t build_cmd(input logic [63:0] op, input logic [63:0] regs,
                                           input logic [63:0] imm);
        exu_cmd_t c;
        c.ialu_op    = ialu_op_e'(op[36]);
        c.ialu_cmd   = ialu_cmd_e'(op[32:28]);
        c.sum2_op    = sum2_op_e'(op[24]);
        c.lsu_cmd    = lsu_cmd_e'(op[23:20]);
        c.rd_wb_sel  = rd_wb_sel_e'(op[18:16]);
        c.jump_req   = op[12];
        c.branch_req = op[8];
        c.exc_req    = op[4];
        c.exc_code   = exc_code_e'(op[3:0]);
        c.rs1_addr   = regs[20:16];
        c.rs2_addr   = regs[12:8];
        c.rd_addr    = regs[4:0];
        c.imm        = imm[31:0];
        return c;
    endfunction

    task run_test(input int t);
        int          base;
        int          tn;
        int          kind;
        int          errs_before;
        logic [31:0] e1;
        logic [31:0] e2;
        exu_cmd_t    c;
        base = t * NCOL;
        tn = t + 1;
        c = build_cmd(stim[base+3], stim[base+4], stim[base+5]);
        kind = int'(stim[base+6]);
        e1 = stim[base+7][31:0];
        e2 = stim[base+8][31:0];
        errs_before = errors;
        @(negedge clk);
        check_val("curr_pc", curr_pc, exp_pc, tn);
        @(posedge clk);
        rf0.preset(c.rs1_addr, stim[base+1][31:0]);
        rf0.preset(c.rs2_addr, stim[base+2][31:0]);
        cmd_valid <= 1'b1;
        cmd <= c;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        while (!instret) begin
            assert (!cmd_ready) else begin
                $display("Test %0d: cmd_ready went high while a load/store was waiting", tn);
                errors++;
            end
            @(negedge clk);
        end
        case (kind)
            0: begin
                check_val("rf_wr.en", 32'(rf_wr.en), 32'd1, tn);
                check_val("rf_wr.addr", 32'(rf_wr.addr), 32'(c.rd_addr), tn);
                check_val("rf_wr.data", rf_wr.data, e1, tn);
                check_val("new_pc_req", 32'(new_pc_req), 32'd0, tn);
                exp_pc = exp_pc + 32'd4;
            end
            1: begin
                check_val("new_pc_req", 32'(new_pc_req), 32'd1, tn);
                check_val("exc_req", 32'(exc_req), 32'd0, tn);
                check_val("new_pc", new_pc, e1, tn);
                exp_pc = e1;
            end
            2: begin
                check_val("exc_req", 32'(exc_req), 32'd1, tn);
                check_val("exc_code", 32'(trap.exc_code), e1, tn);
                check_val("trap_val", trap.trap_val, e2, tn);
                check_val("rf_wr.en", 32'(rf_wr.en), 32'd0, tn);
                check_val("new_pc", new_pc, `EXU_TRAP_VECTOR, tn);
                exp_pc = `EXU_TRAP_VECTOR;
            end
            default: begin
                check_val("new_pc_req", 32'(new_pc_req), 32'd0, tn);
                check_val("exc_req", 32'(exc_req), 32'd0, tn);
                check_val("rf_wr.en", 32'(rf_wr.en), 32'd0, tn);
                exp_pc = exp_pc + 32'd4;
            end
        endcase
        if (errors == errs_before) begin
            n_pass++;
            $display("test %0d passed", tn);
        end else begin
            n_fail++;
            $display("test %0d failed", tn);
        end
    endtask

    // Two adds, a jump, then an add that the redirect refuses once
    task back_to_back(input int tn);
        exu_cmd_t seq [4];
        int       acc_cyc [4];
        int       ret_cyc [4];
        int       k;
        int       rets;
        int       cyc;
        int       errs_before;
        logic     take;
        seq[0] = build_cmd(64'h0010010000, 64'h0, 64'h0);
        seq[1] = seq[0];
        seq[2] = build_cmd(64'h0001001000, 64'h0, 64'h10);
        seq[3] = seq[0];
        k = 0;
        rets = 0;
        cyc = 0;
        errs_before = errors;
        @(negedge clk);
        check_val("curr_pc", curr_pc, exp_pc, tn);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd <= seq[0];
        while (rets < 4) begin
            @(negedge clk);
            if (instret) begin
                ret_cyc[rets] = cyc;
                rets++;
            end
            assert (!(new_pc_req && cmd_ready)) else begin
                $display("Test %0d: a command was accepted in the redirect cycle", tn);
                errors++;
            end
            take = cmd_valid & cmd_ready;
            if (take) begin
                acc_cyc[k] = cyc;
                k++;
            end
            @(posedge clk);
            if (take && k < 4) cmd <= seq[k];
            if (take && k == 4) cmd_valid <= 1'b0;
            cyc++;
        end
        check_val("accept gap of adds", 32'(acc_cyc[1] - acc_cyc[0]), 32'd1, tn);
        check_val("accept gap after jump", 32'(acc_cyc[3] - acc_cyc[2]), 32'd2, tn);
        // Each command retires in the cycle after its acceptance
        for (int i = 0; i < 4; i++) begin
            check_val("retire delay", 32'(ret_cyc[i] - acc_cyc[i]), 32'd1, tn);
        end
        if (errors == errs_before) begin
            n_pass++;
            $display("test %0d passed", tn);
        end else begin
            n_fail++;
            $display("test %0d failed", tn);
        end
    endtask

    initial begin
        for (int i = 0; i < MAX_TESTS * NCOL; i++) stim[i] = '1;
        $readmemh("test/exu_stim.txt", stim);
        while (n_tests < MAX_TESTS && stim[n_tests*NCOL] !== {64{1'b1}}) n_tests++;
        cycle_limit = (n_tests + 1) * 8 + 50;
        exp_pc = `EXU_RST_VECTOR;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < n_tests; t++) run_test(t);
        back_to_back(n_tests + 1);
        $display("%0d tests passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

// ==== test/tb_models.sv ====
/*
 * Testbench models: register file and data memory
 * Memory acks after a random delay and faults at or above 0x400
 */

`timescale 1ns/1ps

module rf_model (
    input  logic                clk,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [31:0]         rs1_data,
    output logic [31:0]         rs2_data,
    input  exu_pkg::rf_wr_t     rf_wr
);
    logic [31:0] regs [0:31];

    initial begin
        for (int i = 0; i < 32; i++) regs[i] <= '0;
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

    always @(posedge clk) begin
        if (rf_wr.en && rf_wr.addr != 5'd0) regs[rf_wr.addr] <= rf_wr.data;
    end

    // Register setup between commands
    task preset(input logic [4:0] a, input logic [31:0] v);
        if (a != 5'd0) regs[a] <= v;
    endtask
endmodule

module dmem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dmem_req,
    input  exu_pkg::dmem_req_t  dmem_cmd,
    output logic                dmem_ack,
    output logic [31:0]         dmem_rdata,
    output exu_pkg::mem_resp_e  dmem_resp
);
    import exu_pkg::*;

    logic [31:0] mem [0:255];
    logic [31:0] seed = 32'd78;
    logic        counting;
    logic [1:0]  wait_cnt;
    logic [3:0]  be;
    logic [7:0]  idx;

    // LCG, upper bits give the extra ack delay
    function automatic logic [1:0] next_delay();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[17:16];
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) mem[i] <= '0;
    end

    assign idx = dmem_cmd.addr[9:2];

    always_comb begin
        case (dmem_cmd.width)
            MEM_WIDTH_BYTE:  be = 4'b0001 << dmem_cmd.addr[1:0];
            MEM_WIDTH_HWORD: be = 4'b0011 << dmem_cmd.addr[1:0];
            default:         be = 4'b1111;
        endcase
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_ack   <= 1'b0;
            counting   <= 1'b0;
            wait_cnt   <= 2'd0;
            dmem_rdata <= '0;
            dmem_resp  <= MEM_RESP_OK;
        end else if (dmem_req && dmem_ack) begin
            dmem_ack <= 1'b0;
            counting <= 1'b0;
            if (dmem_cmd.addr >= 32'h400) begin
                dmem_resp  <= MEM_RESP_ERR;                 // Outside the 256 words
                dmem_rdata <= '0;
            end else begin
                dmem_resp  <= MEM_RESP_OK;
                dmem_rdata <= mem[idx];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_cmd.wr && be[b]) mem[idx][8*b +: 8] <= dmem_cmd.wdata[8*b +: 8];
                end
            end
        end else if (dmem_req) begin
            if (!counting) begin
                counting <= 1'b1;
                wait_cnt <= next_delay();
            end else if (wait_cnt == 2'd0) begin
                dmem_ack <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end
endmodule
